/* all.f */
core_pkg.sv
rf_if.sv
instr_mem.sv
fetch_unit.sv
pipe_reg.sv
register_file.sv
decode_unit.sv
alu.sv
core_top.sv
core_props.sv
tb_core.sv

/* alu.sv */
// ALU operation control from funct fields and the integer result
`timescale 1ns/1ps

module alu (
  input  core_pkg::exec_pl_t in_pl,
  output core_pkg::wb_pl_t   out_pl
);

  core_pkg::alu_op_e op;
  core_pkg::word_t   result;

  // SUB only exists in register form
  always_comb
  begin
    case (in_pl.fn.funct3)
      core_pkg::f3_add_sub:
        op = (in_pl.fn.is_reg && in_pl.fn.funct7_5) ? core_pkg::alu_sub : core_pkg::alu_add;
      core_pkg::f3_xor: op = core_pkg::alu_xor;
      core_pkg::f3_or:  op = core_pkg::alu_or;
      core_pkg::f3_and: op = core_pkg::alu_and;
      default:          op = core_pkg::alu_add;
    endcase
  end

  always_comb
  begin
    case (op)
      core_pkg::alu_add: result = in_pl.opnd_a + in_pl.opnd_b;
      core_pkg::alu_sub: result = in_pl.opnd_a - in_pl.opnd_b;
      core_pkg::alu_and: result = in_pl.opnd_a & in_pl.opnd_b;
      core_pkg::alu_or:  result = in_pl.opnd_a | in_pl.opnd_b;
      core_pkg::alu_xor: result = in_pl.opnd_a ^ in_pl.opnd_b;
      default:           result = '0;
    endcase
  end

  assign out_pl.rd        = in_pl.rd;
  assign out_pl.result    = result;
  assign out_pl.reg_write = in_pl.reg_write;

endmodule

/* core_pkg.sv */
// Core widths, opcodes, funct3 codes, ALU operations and stage payload types
package core_pkg;

  // Datapath and register index widths
  localparam int xlen      = 32;
  localparam int reg_idx_w = 5;

  // Instruction store geometry, in words
  localparam int imem_depth  = 64;
  localparam int imem_addr_w = 6;

  typedef logic [xlen-1:0]      word_t;
  typedef logic [reg_idx_w-1:0] reg_idx_t;

  // RV32I opcodes that the core executes
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;

  // funct3 codes shared by register and immediate forms
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor
  } alu_op_e;

  // Raw operation fields handed from decode to the ALU control
  typedef struct packed {
    logic       is_reg;
    logic       funct7_5;
    logic [2:0] funct3;
  } alu_fn_t;

  typedef struct packed {
    word_t pc;
    word_t instr;
  } fetch_pl_t;

  typedef struct packed {
    word_t    opnd_a;
    word_t    opnd_b;
    alu_fn_t  fn;
    reg_idx_t rd;
    logic     reg_write;
  } exec_pl_t;

  typedef struct packed {
    reg_idx_t rd;
    word_t    result;
    logic     reg_write;
  } wb_pl_t;

endpackage

/* core_props.sv */
// Concurrent checks on write-back index, stall length with its bubble and quiet time after reset
`timescale 1ns/1ps

module core_props (
  input logic               clk,
  input logic               rst,
  input logic               wb_valid,
  input core_pkg::reg_idx_t wb_idx,
  input logic               stall,
  input logic               ex_valid
);

  // x0 is never reported as a destination
  property wb_idx_nonzero;
    @(posedge clk) disable iff (rst)
      wb_valid |-> (wb_idx != '0);
  endproperty

  // A hazard stall lasts one cycle and leaves a bubble in execute
  property stall_single_cycle;
    @(posedge clk) disable iff (rst)
      stall |=> (!stall && !ex_valid);
  endproperty

  // Pipeline still empty for three cycles once reset drops
  property quiet_after_reset;
    @(posedge clk)
      (!rst && ($past(rst) || $past(rst, 2) || $past(rst, 3))) |-> !wb_valid;
  endproperty

  assert property (wb_idx_nonzero)
  else $error("Write-back reported for register index 0");

  assert property (stall_single_cycle)
  else $error("Stall held longer than one cycle or no bubble entered execute");

  assert property (quiet_after_reset)
  else $error("Write-back within three cycles of reset release");

endmodule

// Decode stall and execute valid are visible as top-level wires
bind core_top core_props u_props (
  .clk(clk), .rst(rst), .wb_valid(wb_valid), .wb_idx(wb_idx),
  .stall(stall), .ex_valid(de_valid)
);

/* core_top.sv */
// Pipeline top with fetch, decode, execute and write-back stage wiring
`timescale 1ns/1ps

module core_top (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             run,
  input  logic                             prog_we,
  input  logic [core_pkg::imem_addr_w-1:0] prog_addr,
  input  core_pkg::word_t                  prog_data,
  output logic                             wb_valid,
  output core_pkg::reg_idx_t               wb_idx,
  output core_pkg::word_t                  wb_data
);

  logic [core_pkg::imem_addr_w-1:0] imem_addr;
  core_pkg::word_t                  imem_data;
  logic                             stall;
  logic                             if_valid, fd_valid, de_valid, ew_valid;
  core_pkg::fetch_pl_t              if_pl, fd_pl;
  core_pkg::exec_pl_t               id_pl, de_pl;
  core_pkg::wb_pl_t                 ex_pl, ew_pl;

  rf_if rf_bus ();

  // Loading is locked out while the core runs
  instr_mem u_imem (.clk(clk), .rst(rst), .we(prog_we && !run), .waddr(prog_addr),
                    .wdata(prog_data), .raddr(imem_addr), .rdata(imem_data));

  fetch_unit u_fetch (.clk(clk), .rst(rst), .run(run), .stall(stall), .imem_addr(imem_addr),
                      .imem_data(imem_data), .out_valid(if_valid), .out_pl(if_pl));

  pipe_reg #(.payload_t(core_pkg::fetch_pl_t)) fd (.clk(clk), .rst(rst), .hold(stall),
    .bubble(1'b0), .in_valid(if_valid), .in_pl(if_pl), .out_valid(fd_valid), .out_pl(fd_pl));

  register_file u_rf (.clk(clk), .rst(rst), .rf(rf_bus.regfile));

  decode_unit u_decode (.in_valid(fd_valid), .in_pl(fd_pl), .rf(rf_bus.decoder),
                        .ex_valid(de_valid), .ex_rd(de_pl.rd), .ex_reg_write(de_pl.reg_write),
                        .stall(stall), .out_pl(id_pl));

  // A stalled decode leaves a bubble in execute
  pipe_reg #(.payload_t(core_pkg::exec_pl_t)) de (.clk(clk), .rst(rst), .hold(1'b0),
    .bubble(stall), .in_valid(fd_valid), .in_pl(id_pl), .out_valid(de_valid), .out_pl(de_pl));

  alu u_alu (.in_pl(de_pl), .out_pl(ex_pl));

  pipe_reg #(.payload_t(core_pkg::wb_pl_t)) ew (.clk(clk), .rst(rst), .hold(1'b0),
    .bubble(1'b0), .in_valid(de_valid), .in_pl(ex_pl), .out_valid(ew_valid), .out_pl(ew_pl));

  assign rf_bus.wr_en   = ew_valid && ew_pl.reg_write;
  assign rf_bus.wr_idx  = ew_pl.rd;
  assign rf_bus.wr_data = ew_pl.result;

  assign wb_valid = ew_valid && ew_pl.reg_write && (ew_pl.rd != '0);
  assign wb_idx   = ew_pl.rd;
  assign wb_data  = ew_pl.result;

endmodule

/* decode_unit.sv */
// Control decode, immediate extension, operand select and hazard stall
`timescale 1ns/1ps

module decode_unit (
  input  logic                in_valid,
  input  core_pkg::fetch_pl_t in_pl,
  rf_if.decoder               rf,
  input  logic                ex_valid,
  input  core_pkg::reg_idx_t  ex_rd,
  input  logic                ex_reg_write,
  output logic                stall,
  output core_pkg::exec_pl_t  out_pl
);

  logic [6:0]         opcode;
  logic [2:0]         funct3;
  core_pkg::reg_idx_t rs1;
  core_pkg::reg_idx_t rs2;
  core_pkg::reg_idx_t rd;
  logic               is_reg;
  logic               is_imm;
  logic               funct_ok;
  core_pkg::word_t    imm;
  logic               hit_1;
  logic               hit_2;

  // Instruction fields
  assign opcode = in_pl.instr[6:0];
  assign rd     = in_pl.instr[11:7];
  assign funct3 = in_pl.instr[14:12];
  assign rs1    = in_pl.instr[19:15];
  assign rs2    = in_pl.instr[24:20];

  assign is_reg = (opcode == core_pkg::opc_op);
  assign is_imm = (opcode == core_pkg::opc_op_imm);

  // Shifts and compares are not implemented, so they write nothing
  always_comb
  begin
    case (funct3)
      core_pkg::f3_add_sub,
      core_pkg::f3_xor,
      core_pkg::f3_or,
      core_pkg::f3_and: funct_ok = 1'b1;
      default:          funct_ok = 1'b0;
    endcase
  end

  // I-type immediate, bits 31 to 20
  assign imm = {{(core_pkg::xlen-12){in_pl.instr[31]}}, in_pl.instr[31:20]};

  assign rf.rd_idx_1 = rs1;
  assign rf.rd_idx_2 = rs2;

  always_comb
  begin
    out_pl.opnd_a      = rf.rd_data_1;
    out_pl.opnd_b      = is_imm ? imm : rf.rd_data_2;
    out_pl.fn.is_reg   = is_reg;
    out_pl.fn.funct7_5 = in_pl.instr[30];
    out_pl.fn.funct3   = funct3;
    out_pl.rd          = rd;
    out_pl.reg_write   = (is_reg || is_imm) && funct_ok;
  end

  // rs2 is a source only for register ops
  assign hit_1 = (is_reg || is_imm) && (rs1 == ex_rd);
  assign hit_2 = is_reg && (rs2 == ex_rd);

  // Result lands in the register file one cycle later and is read through
  assign stall = in_valid && ex_valid && ex_reg_write && (ex_rd != '0) && (hit_1 || hit_2);

endmodule

/* fetch_unit.sv */
// Program counter with run gating, stall hold and fetch payload assembly
`timescale 1ns/1ps

module fetch_unit (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             run,
  input  logic                             stall,
  output logic [core_pkg::imem_addr_w-1:0] imem_addr,
  input  core_pkg::word_t                  imem_data,
  output logic                             out_valid,
  output core_pkg::fetch_pl_t              out_pl
);

  core_pkg::word_t pc;
  core_pkg::word_t pc_next;

  // Wrap back to word 0 past the end of the store
  always_comb
  begin
    pc_next = pc + core_pkg::word_t'(4);
    if (pc_next == core_pkg::word_t'(core_pkg::imem_depth * 4))
      pc_next = '0;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      pc <= '0;
    else if (run && !stall)
      pc <= pc_next;
  end

  // Word address drops the byte offset
  assign imem_addr = pc[core_pkg::imem_addr_w+1:2];

  assign out_valid    = run;
  assign out_pl.pc    = pc;
  assign out_pl.instr = imem_data;

endmodule

/* instr_mem.sv */
// Instruction store with a program load port and asynchronous read
`timescale 1ns/1ps

module instr_mem (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                we,
  input  logic [core_pkg::imem_addr_w-1:0]    waddr,
  input  core_pkg::word_t                     wdata,
  input  logic [core_pkg::imem_addr_w-1:0]    raddr,
  output core_pkg::word_t                     rdata
);

  core_pkg::word_t mem [core_pkg::imem_depth];

  // All-zero words decode as no-ops after reset
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < core_pkg::imem_depth; i++)
      begin
        mem[i] <= '0;
      end
    end
    else if (we)
    begin
      mem[waddr] <= wdata;
    end
  end

  // Fetch sees the word in the same cycle
  assign rdata = mem[raddr];

endmodule

/* pipe_reg.sv */
// Generic stage register with valid bit, hold and bubble insertion
`timescale 1ns/1ps

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     hold,
  input  logic     bubble,
  input  logic     in_valid,
  input  payload_t in_pl,
  output logic     out_valid,
  output payload_t out_pl
);

  // Bubble wins over hold
  always_ff @(posedge clk)
  begin
    if (rst || bubble)
      out_valid <= 1'b0;
    else if (!hold)
      out_valid <= in_valid;
  end

  // Payload only matters while valid is high
  always_ff @(posedge clk)
  begin
    if (!hold)
      out_pl <= in_pl;
  end

endmodule

/* register_file.sv */
// Register file of 32 words, x0 tied to zero, with write-through reads
`timescale 1ns/1ps

module register_file (
  input  logic clk,
  input  logic rst,
  rf_if.regfile rf
);

  core_pkg::word_t regs [2**core_pkg::reg_idx_w];

  function automatic core_pkg::word_t read_port(core_pkg::reg_idx_t idx);
    core_pkg::word_t val;
    if (idx == '0)
      val = '0;
    else if (rf.wr_en && rf.wr_idx == idx)
      val = rf.wr_data;
    else
      val = regs[idx];
    return val;
  endfunction

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < 2**core_pkg::reg_idx_w; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (rf.wr_en && rf.wr_idx != '0)
    begin
      regs[rf.wr_idx] <= rf.wr_data;
    end
  end

  // Same-cycle write is visible to decode
  always_comb
  begin
    rf.rd_data_1 = read_port(rf.rd_idx_1);
    rf.rd_data_2 = read_port(rf.rd_idx_2);
  end

endmodule

/* rf_if.sv */
// Register file bus with two read ports, one write port and their modports
`timescale 1ns/1ps

interface rf_if;
  core_pkg::reg_idx_t rd_idx_1;
  core_pkg::reg_idx_t rd_idx_2;
  core_pkg::word_t    rd_data_1;
  core_pkg::word_t    rd_data_2;
  logic               wr_en;
  core_pkg::reg_idx_t wr_idx;
  core_pkg::word_t    wr_data;

  modport decoder (
    output rd_idx_1, rd_idx_2,
    input  rd_data_1, rd_data_2
  );

  modport regfile (
    input  rd_idx_1, rd_idx_2, wr_en, wr_idx, wr_data,
    output rd_data_1, rd_data_2
  );
endinterface

/* run.sh */
#!/bin/sh
# Compile and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_core -o tb_core_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

out=$(./obj_dir/tb_core_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "All tests passed"; then
  exit 0
fi
exit 1

/* tb_core.sv */
// Testbench for core_top with program table, load, run and write-back checks
`timescale 1ns/1ps

module tb_core;

  localparam int max_rows     = 32;
  localparam int drain_cycles = 20;

  // RV32I funct fields used to build the program
  localparam logic [2:0] fn_add  = 3'b000;
  localparam logic [2:0] fn_xor  = 3'b100;
  localparam logic [2:0] fn_or   = 3'b110;
  localparam logic [2:0] fn_and  = 3'b111;
  localparam logic [6:0] f7_base = 7'h00;
  localparam logic [6:0] f7_sub  = 7'h20;

  logic                             clk;
  logic                             rst;
  logic                             run;
  logic                             prog_we;
  logic [core_pkg::imem_addr_w-1:0] prog_addr;
  core_pkg::word_t                  prog_data;
  logic                             wb_valid;
  core_pkg::reg_idx_t               wb_idx;
  core_pkg::word_t                  wb_data;

  // Program rows: instruction, expect_write, expected rd, expected data
  core_pkg::word_t    row_instr [max_rows];
  logic               row_write [max_rows];
  core_pkg::reg_idx_t row_rd    [max_rows];
  core_pkg::word_t    row_data  [max_rows];
  int                 n_rows = 0;

  core_pkg::reg_idx_t exp_rd_q   [$];
  core_pkg::word_t    exp_data_q [$];
  int                 n_seen      = 0;
  int                 cycle_count = 0;
  int                 cycle_limit = 0;

  core_top dut (
    .clk(clk), .rst(rst), .run(run), .prog_we(prog_we), .prog_addr(prog_addr),
    .prog_data(prog_data), .wb_valid(wb_valid), .wb_idx(wb_idx), .wb_data(wb_data)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_with_failure();
    $display("Some tests failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_idx(string name, core_pkg::reg_idx_t got, core_pkg::reg_idx_t exp);
    if (got !== exp)
    begin
      $display("Fail at %0t: %s expected %0d, got %0d", $time, name, exp, got);
      stop_with_failure();
    end
  endtask

  task automatic check_word(string name, core_pkg::word_t got, core_pkg::word_t exp);
    if (got !== exp)
    begin
      $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, got);
      stop_with_failure();
    end
  endtask

  function automatic core_pkg::word_t enc_r(logic [6:0] f7, logic [2:0] f3,
                                            core_pkg::reg_idx_t rd, rs1, rs2);
    return {f7, rs2, rs1, f3, rd, core_pkg::opc_op};
  endfunction

  function automatic core_pkg::word_t enc_i(logic [2:0] f3, core_pkg::reg_idx_t rd,
                                            core_pkg::reg_idx_t rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, core_pkg::opc_op_imm};
  endfunction

  task automatic add_row(core_pkg::word_t instr, logic wr, core_pkg::reg_idx_t rd,
                         core_pkg::word_t data);
    row_instr[n_rows] = instr;
    row_write[n_rows] = wr;
    row_rd[n_rows]    = rd;
    row_data[n_rows]  = data;
    n_rows++;
  endtask

  task automatic build_program();
    // Immediates, negative ones included
    add_row(enc_i(fn_add, 5'd1, 5'd0, 12'h005), 1'b1, 5'd1, 32'h0000_0005);
    add_row(enc_i(fn_add, 5'd2, 5'd0, 12'hffd), 1'b1, 5'd2, 32'hffff_fffd);
    add_row(enc_i(fn_add, 5'd3, 5'd0, 12'h7ff), 1'b1, 5'd3, 32'h0000_07ff);
    add_row(enc_i(fn_add, 5'd4, 5'd0, 12'h800), 1'b1, 5'd4, 32'hffff_f800);
    // Register ops on the values above
    add_row(enc_r(f7_base, fn_add, 5'd5, 5'd1, 5'd2), 1'b1, 5'd5, 32'h0000_0002);
    add_row(enc_r(f7_sub, fn_add, 5'd6, 5'd1, 5'd3), 1'b1, 5'd6, 32'hffff_f806);
    add_row(enc_r(f7_base, fn_and, 5'd7, 5'd3, 5'd4), 1'b1, 5'd7, 32'h0000_0000);
    add_row(enc_r(f7_base, fn_or, 5'd8, 5'd3, 5'd4), 1'b1, 5'd8, 32'hffff_ffff);
    add_row(enc_r(f7_base, fn_xor, 5'd9, 5'd1, 5'd2), 1'b1, 5'd9, 32'hffff_fff8);
    add_row(enc_i(fn_and, 5'd10, 5'd2, 12'h0f0), 1'b1, 5'd10, 32'h0000_00f0);
    add_row(enc_i(fn_or, 5'd11, 5'd1, 12'h100), 1'b1, 5'd11, 32'h0000_0105);
    add_row(enc_i(fn_xor, 5'd12, 5'd1, 12'hfff), 1'b1, 5'd12, 32'hffff_fffa);
    // Back to back dependent chain
    add_row(enc_i(fn_add, 5'd13, 5'd0, 12'h001), 1'b1, 5'd13, 32'h0000_0001);
    add_row(enc_i(fn_add, 5'd13, 5'd13, 12'h002), 1'b1, 5'd13, 32'h0000_0003);
    add_row(enc_r(f7_base, fn_add, 5'd14, 5'd13, 5'd13), 1'b1, 5'd14, 32'h0000_0006);
    add_row(enc_r(f7_sub, fn_add, 5'd15, 5'd14, 5'd1), 1'b1, 5'd15, 32'h0000_0001);
    add_row(enc_r(f7_base, fn_xor, 5'd15, 5'd15, 5'd14), 1'b1, 5'd15, 32'h0000_0007);
    // rd of 0, all-zero word and LUI x5 are no-ops
    add_row(enc_i(fn_add, 5'd0, 5'd1, 12'h007), 1'b0, 5'd0, 32'h0000_0000);
    add_row(32'h0000_0000, 1'b0, 5'd0, 32'h0000_0000);
    add_row(32'h1234_52b7, 1'b0, 5'd0, 32'h0000_0000);
    add_row(enc_r(f7_base, fn_or, 5'd16, 5'd15, 5'd13), 1'b1, 5'd16, 32'h0000_0007);
    add_row(enc_r(f7_base, fn_add, 5'd17, 5'd16, 5'd12), 1'b1, 5'd17, 32'h0000_0001);
    add_row(enc_r(f7_sub, fn_add, 5'd18, 5'd0, 5'd17), 1'b1, 5'd18, 32'hffff_ffff);
    add_row(enc_r(f7_base, fn_add, 5'd20, 5'd0, 5'd1), 1'b1, 5'd20, 32'h0000_0005);
    add_row(enc_i(fn_add, 5'd0, 5'd0, 12'h009), 1'b0, 5'd0, 32'h0000_0000);
    add_row(enc_r(f7_base, fn_add, 5'd21, 5'd0, 5'd3), 1'b1, 5'd21, 32'h0000_07ff);
  endtask

  // Write-back sampled on the falling edge, away from register updates
  always @(negedge clk)
  begin
    if (!rst && wb_valid)
    begin
      if (!run)
      begin
        $display("Write-back seen at %0t while run is low", $time);
        stop_with_failure();
      end
      else if (n_seen >= exp_rd_q.size())
      begin
        $display("Write-back seen at %0t after the last expected write", $time);
        stop_with_failure();
      end
      else
      begin
        check_idx("wb_idx", wb_idx, exp_rd_q[n_seen]);
        check_word("wb_data", wb_data, exp_data_q[n_seen]);
        n_seen++;
      end
    end
  end

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit)
    begin
      $display("Timeout after %0d cycles before the program finished", cycle_count);
      stop_with_failure();
    end
  end

  initial
  begin
    rst       = 1'b1;
    run       = 1'b0;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    build_program();
    for (int i = 0; i < n_rows; i++)
    begin
      if (row_write[i])
      begin
        exp_rd_q.push_back(row_rd[i]);
        exp_data_q.push_back(row_data[i]);
      end
    end
    cycle_limit = 4 * n_rows + 60;

    repeat (16) @(posedge clk);
    rst <= 1'b0;

    // One word per cycle with run low
    for (int i = 0; i < n_rows; i++)
    begin
      @(posedge clk);
      prog_we   <= 1'b1;
      prog_addr <= i[core_pkg::imem_addr_w-1:0];
      prog_data <= row_instr[i];
    end
    @(posedge clk);
    prog_we <= 1'b0;
    repeat (4) @(posedge clk);
    run <= 1'b1;

    while (n_seen < exp_rd_q.size())
      @(posedge clk);
    repeat (drain_cycles) @(posedge clk);

    if (n_seen == exp_rd_q.size())
    begin
      $display("All tests passed");
      $finish;
    end
    else
    begin
      $display("Saw %0d write-backs, expected %0d", n_seen, exp_rd_q.size());
      stop_with_failure();
    end
  end

endmodule
